/* list.f */
+incdir+src
src/datapath_pkg.sv
src/busMux.sv
src/registerFile.sv
src/memInterface.sv
src/controlRegs.sv
src/aluUnit.sv
src/datapath.sv
sim/datapath_asserts.sv
sim/datapath_tb.sv

/* sim/datapath_asserts.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module datapathAsserts (
    input logic                  Clock,
    input logic                  rstN,
    input datapath_pkg::regSel_t regOut,
    input logic                  pcOut,
    input logic                  zHighOut,
    input logic                  zLowOut,
    input logic                  hiOut,
    input logic                  loOut,
    input logic                  mdrOut,
    input logic                  marIn,
    input datapath_pkg::word_t   marValue,
    input datapath_pkg::word_t   busData
);

    logic [`REG_COUNT+5:0] outStrobes;

    assign outStrobes = {regOut, pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut};

    // Only one unit may drive the bus.
    outExclusive: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(outStrobes))
        else $error("more than one bus source strobe is high");

    marHold: assert property (@(posedge Clock) disable iff (!rstN)
        !marIn |=> $stable(marValue))
        else $error("MAR changed without a load strobe");

    idleBusZero: assert property (@(posedge Clock) disable iff (!rstN)
        (outStrobes == '0) |-> (busData == '0))
        else $error("bus is not zero with no source selected");

endmodule

bind datapath datapathAsserts datapathAsserts_i (.*);

/* sim/datapath_tb.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module datapath_tb;

    localparam int ResetCycles = 10;
    localparam int Rows = 17;
    localparam int CycleLimit = 2 * (ResetCycles + Rows * 12 + 40);

    logic Clock, rstN, read, incPc, pcIn, zIn, mdrIn, marIn, yIn, hiIn, loIn, irIn;
    logic pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut;
    datapath_pkg::regSel_t regIn, regOut;
    datapath_pkg::opcode_t opcode;
    datapath_pkg::word_t   mDataIn, busData, marValue, irValue;

    datapath_pkg::opcode_t opTable [Rows];
    datapath_pkg::word_t   aTable [Rows], bTable [Rows], lowTable [Rows], highTable [Rows];
    datapath_pkg::word_t   regModel [`REG_COUNT];
    datapath_pkg::word_t   pcStart, irWord;
    logic [31:0] seed = 32'hf68d7ddc;
    int errors = 0;
    int cycles = 0;

    datapath dut_i (.*);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic datapath_pkg::word_t nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic checkValue(input string name, input datapath_pkg::word_t got,
                              input datapath_pkg::word_t expected);
        if (got !== expected) begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
        end
    endtask

    // Expected Z halves, worked out from the ALU rules.
    task automatic computeExpected(input datapath_pkg::opcode_t op,
                                   input datapath_pkg::word_t a, input datapath_pkg::word_t b,
                                   output datapath_pkg::word_t lo, output datapath_pkg::word_t hi);
        logic [63:0] prod;
        int s;
        s = b[4:0];
        prod = {32'b0, a} * {32'b0, b};
        hi = '0;
        case (op)
            datapath_pkg::OP_ADD:  lo = a + b;
            datapath_pkg::OP_SUB:  lo = a + ~b + 1;
            datapath_pkg::OP_AND:  lo = a & b;
            datapath_pkg::OP_OR:   lo = a | b;
            datapath_pkg::OP_SHL:  lo = a << s;
            datapath_pkg::OP_SHR:  lo = a >> s;
            datapath_pkg::OP_SHRA: lo = (a >> s) | ((a[31] && s != 0) ? ~(32'hffffffff >> s) : 0);
            datapath_pkg::OP_ROL:  lo = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
            datapath_pkg::OP_ROR:  lo = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
            datapath_pkg::OP_NEG:  lo = ~b + 1;
            datapath_pkg::OP_NOT:  lo = ~b;
            datapath_pkg::OP_MUL: begin
                lo = prod[31:0];
                hi = prod[63:32];
            end
            datapath_pkg::OP_DIV: begin
                lo = (b == 0) ? 32'hffffffff : a / b;
                hi = (b == 0) ? a : a % b;
            end
            default: lo = '0;
        endcase
    endtask

    task automatic buildTable();
        datapath_pkg::opcode_t ops [13];
        ops = '{datapath_pkg::OP_ADD, datapath_pkg::OP_SUB, datapath_pkg::OP_AND,
                datapath_pkg::OP_OR, datapath_pkg::OP_SHL, datapath_pkg::OP_SHR,
                datapath_pkg::OP_SHRA, datapath_pkg::OP_ROL, datapath_pkg::OP_ROR,
                datapath_pkg::OP_NEG, datapath_pkg::OP_NOT, datapath_pkg::OP_MUL,
                datapath_pkg::OP_DIV};
        for (int i = 0; i < 13; i++) begin
            opTable[i] = ops[i];
            aTable[i] = nextRandom();
            bTable[i] = nextRandom();
        end
        // Keep the random divisor small enough for a nonzero quotient.
        bTable[12] = bTable[12] >> 18;
        opTable[13] = datapath_pkg::OP_SHL;
        aTable[13] = nextRandom();
        bTable[13] = 32'd0;
        opTable[14] = datapath_pkg::OP_SHR;
        aTable[14] = nextRandom();
        bTable[14] = 32'd31;
        opTable[15] = datapath_pkg::OP_DIV;
        aTable[15] = nextRandom();
        bTable[15] = 32'd0;
        opTable[16] = datapath_pkg::OP_SHRA;
        aTable[16] = 32'h8765_4321;
        bTable[16] = 32'd12;
        for (int i = 0; i < Rows; i++) begin
            computeExpected(opTable[i], aTable[i], bTable[i], lowTable[i], highTable[i]);
        end
    endtask

    task automatic clearStrobes();
        {read, incPc, pcIn, zIn, mdrIn, marIn, yIn, hiIn, loIn, irIn} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut} = '0;
        regIn = '0;
        regOut = '0;
    endtask

    // Strobes set 2 ns after an edge are held for exactly one clock.
    task automatic endStep();
        @(posedge Clock);
        #2;
        clearStrobes();
    endtask

    task automatic readAndCheck(input string name, input datapath_pkg::word_t expected);
        #5;
        checkValue(name, busData, expected);
        endStep();
    endtask

    task automatic readMemory(input datapath_pkg::word_t value);
        mDataIn = value;
        read = 1'b1;
        mdrIn = 1'b1;
        endStep();
    endtask

    task automatic loadRegister(input int k, input datapath_pkg::word_t value);
        readMemory(value);
        mdrOut = 1'b1;
        regIn[k] = 1'b1;
        endStep();
        regModel[k] = value;
    endtask

    initial begin
        clearStrobes();
        rstN = 1'b0;
        mDataIn = '0;
        opcode = '0;
        for (int k = 0; k < `REG_COUNT; k++) begin
            regModel[k] = '0;
        end
        buildTable();
        repeat (ResetCycles) @(posedge Clock);
        #2;
        rstN = 1'b1;

        for (int k = 0; k < `REG_COUNT; k++) begin
            regOut[k] = 1'b1;
            readAndCheck($sformatf("busData R%0d after reset", k), '0);
        end
        pcOut = 1'b1;
        readAndCheck("busData PC after reset", '0);
        zLowOut = 1'b1;
        readAndCheck("busData Z low after reset", '0);
        zHighOut = 1'b1;
        readAndCheck("busData Z high after reset", '0);
        hiOut = 1'b1;
        readAndCheck("busData HI after reset", '0);
        loOut = 1'b1;
        readAndCheck("busData LO after reset", '0);
        mdrOut = 1'b1;
        readAndCheck("busData MDR after reset", '0);

        for (int i = 0; i < 4; i++) begin
            loadRegister(4 * i + 3, nextRandom());
        end
        for (int k = 0; k < `REG_COUNT; k++) begin
            regOut[k] = 1'b1;
            readAndCheck($sformatf("busData R%0d", k), regModel[k]);
        end

        for (int r = 0; r < Rows; r++) begin
            loadRegister(3, aTable[r]);
            loadRegister(5, bTable[r]);
            regOut[3] = 1'b1;
            yIn = 1'b1;
            endStep();
            regOut[5] = 1'b1;
            zIn = 1'b1;
            opcode = opTable[r];
            endStep();
            zLowOut = 1'b1;
            regIn[1] = 1'b1;
            loIn = 1'b1;
            endStep();
            regOut[1] = 1'b1;
            readAndCheck($sformatf("busData R1 row %0d", r), lowTable[r]);
            zHighOut = 1'b1;
            hiIn = 1'b1;
            readAndCheck($sformatf("busData Z high row %0d", r), highTable[r]);
            hiOut = 1'b1;
            readAndCheck($sformatf("busData HI row %0d", r), highTable[r]);
            loOut = 1'b1;
            readAndCheck($sformatf("busData LO row %0d", r), lowTable[r]);
        end

        pcStart = nextRandom();
        readMemory(pcStart);
        mdrOut = 1'b1;
        pcIn = 1'b1;
        endStep();
        {pcOut, marIn, incPc, zIn} = 4'b1111;
        endStep();
        zLowOut = 1'b1;
        pcIn = 1'b1;
        endStep();
        checkValue("marValue", marValue, pcStart);
        pcOut = 1'b1;
        readAndCheck("busData PC after increment", pcStart + 32'd1);

        irWord = nextRandom();
        readMemory(irWord);
        mdrOut = 1'b1;
        irIn = 1'b1;
        endStep();
        checkValue("irValue", irValue, irWord);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module aluUnit (
    input  logic                  Clock,
    input  logic                  rstN,
    input  datapath_pkg::word_t   bus,
    input  logic                  yIn,
    input  logic                  zIn,
    input  logic                  incPc,
    input  datapath_pkg::opcode_t opcode,
    output datapath_pkg::dword_t  zData
);

    localparam int ShiftWidth = $clog2(`DATA_WIDTH);

    datapath_pkg::word_t  yReg;
    datapath_pkg::word_t  resLow;
    datapath_pkg::word_t  resHigh;
    datapath_pkg::dword_t product;
    datapath_pkg::dword_t rolWide;
    datapath_pkg::dword_t rorWide;
    datapath_pkg::dword_t zNext;
    logic [ShiftWidth-1:0] shAmt;

    // Operand A comes from Y, operand B straight off the bus.
    always_comb begin
        shAmt   = bus[ShiftWidth-1:0];
        product = datapath_pkg::dword_t'(yReg) * datapath_pkg::dword_t'(bus);
        // Rotates fall out of shifting a doubled copy of A.
        rolWide = {yReg, yReg} << shAmt;
        rorWide = {yReg, yReg} >> shAmt;
        resLow  = '0;
        resHigh = '0;
        case (opcode)
            datapath_pkg::OP_ADD:  resLow = yReg + bus;
            datapath_pkg::OP_SUB:  resLow = yReg - bus;
            datapath_pkg::OP_AND:  resLow = yReg & bus;
            datapath_pkg::OP_OR:   resLow = yReg | bus;
            datapath_pkg::OP_SHR:  resLow = yReg >> shAmt;
            datapath_pkg::OP_SHRA: resLow = $signed(yReg) >>> shAmt;
            datapath_pkg::OP_SHL:  resLow = yReg << shAmt;
            datapath_pkg::OP_ROL:  resLow = rolWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
            datapath_pkg::OP_ROR:  resLow = rorWide[`DATA_WIDTH-1:0];
            datapath_pkg::OP_NEG:  resLow = -bus;
            datapath_pkg::OP_NOT:  resLow = ~bus;
            datapath_pkg::OP_MUL: begin
                resLow  = product[`DATA_WIDTH-1:0];
                resHigh = product[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
            datapath_pkg::OP_DIV: begin
                if (bus == '0) begin
                    // Divide by zero saturates the quotient and keeps A.
                    resLow  = '1;
                    resHigh = yReg;
                end else begin
                    resLow  = yReg / bus;
                    resHigh = yReg % bus;
                end
            end
            default: begin
                resLow  = '0;
                resHigh = '0;
            end
        endcase
    end

    // The PC increment path overrides the opcode.
    always_comb begin
        if (incPc) begin
            zNext = {{`DATA_WIDTH{1'b0}}, bus + 1'b1};
        end else begin
            zNext = {resHigh, resLow};
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            yReg  <= '0;
            zData <= '0;
        end else begin
            if (yIn) begin
                yReg <= bus;
            end
            if (zIn) begin
                zData <= zNext;
            end
        end
    end

endmodule

/* src/busMux.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module busMux (
    input  datapath_pkg::regSel_t regOut,
    input  logic                  pcOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  mdrOut,
    input  datapath_pkg::word_t   regData [`REG_COUNT],
    input  datapath_pkg::word_t   pcData,
    input  datapath_pkg::dword_t  zData,
    input  datapath_pkg::word_t   hiData,
    input  datapath_pkg::word_t   loData,
    input  datapath_pkg::word_t   mdrData,
    output datapath_pkg::word_t   bus
);

    localparam int IdxWidth = $clog2(`REG_COUNT);

    datapath_pkg::busSrc_t src;
    logic [IdxWidth-1:0]   regIdx;

    // Priority encode the out strobes.
    always_comb begin
        src = datapath_pkg::SRC_NONE;
        regIdx = '0;
        if (mdrOut) begin
            src = datapath_pkg::SRC_MDR;
        end else if (zLowOut) begin
            src = datapath_pkg::SRC_ZLOW;
        end else if (zHighOut) begin
            src = datapath_pkg::SRC_ZHIGH;
        end else if (pcOut) begin
            src = datapath_pkg::SRC_PC;
        end else if (hiOut) begin
            src = datapath_pkg::SRC_HI;
        end else if (loOut) begin
            src = datapath_pkg::SRC_LO;
        end else if (|regOut) begin
            src = datapath_pkg::SRC_REG;
            // Scan downward so the lowest index wins.
            for (int i = `REG_COUNT - 1; i >= 0; i--) begin
                if (regOut[i]) begin
                    regIdx = IdxWidth'(i);
                end
            end
        end
    end

    always_comb begin
        case (src)
            datapath_pkg::SRC_REG:   bus = regData[regIdx];
            datapath_pkg::SRC_PC:    bus = pcData;
            datapath_pkg::SRC_ZHIGH: bus = zData[2*`DATA_WIDTH-1:`DATA_WIDTH];
            datapath_pkg::SRC_ZLOW:  bus = zData[`DATA_WIDTH-1:0];
            datapath_pkg::SRC_HI:    bus = hiData;
            datapath_pkg::SRC_LO:    bus = loData;
            datapath_pkg::SRC_MDR:   bus = mdrData;
            default:                 bus = '0;
        endcase
    end

endmodule

/* src/controlRegs.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module controlRegs (
    input  logic                Clock,
    input  logic                rstN,
    input  datapath_pkg::word_t bus,
    input  logic                pcIn,
    input  logic                irIn,
    input  logic                hiIn,
    input  logic                loIn,
    output datapath_pkg::word_t pcData,
    output datapath_pkg::word_t irValue,
    output datapath_pkg::word_t hiData,
    output datapath_pkg::word_t loData
);

    // The PC has no counter of its own.
    // It advances when Z low, holding PC plus one, is written back.
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcData  <= '0;
            irValue <= '0;
            hiData  <= '0;
            loData  <= '0;
        end else begin
            if (pcIn) begin
                pcData <= bus;
            end
            if (irIn) begin
                irValue <= bus;
            end
            // HI and LO take the two halves of a multiply or divide.
            if (hiIn) begin
                hiData <= bus;
            end
            if (loIn) begin
                loData <= bus;
            end
        end
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module datapath (
    input  logic                  Clock,
    input  logic                  rstN,
    input  datapath_pkg::word_t   mDataIn,
    input  logic                  read,
    input  logic                  incPc,
    input  datapath_pkg::regSel_t regIn,
    input  datapath_pkg::regSel_t regOut,
    input  logic                  pcIn,
    input  logic                  zIn,
    input  logic                  mdrIn,
    input  logic                  marIn,
    input  logic                  yIn,
    input  logic                  hiIn,
    input  logic                  loIn,
    input  logic                  irIn,
    input  logic                  pcOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  mdrOut,
    input  datapath_pkg::opcode_t opcode,
    output datapath_pkg::word_t   busData,
    output datapath_pkg::word_t   marValue,
    output datapath_pkg::word_t   irValue
);

    datapath_pkg::word_t  regData [`REG_COUNT];
    datapath_pkg::word_t  pcData;
    datapath_pkg::word_t  hiData;
    datapath_pkg::word_t  loData;
    datapath_pkg::word_t  mdrData;
    datapath_pkg::dword_t zData;

    // The bus is also what a memory write would see.
    busMux busMux_i (
        .regOut(regOut), .pcOut(pcOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .hiOut(hiOut), .loOut(loOut), .mdrOut(mdrOut),
        .regData(regData), .pcData(pcData), .zData(zData),
        .hiData(hiData), .loData(loData), .mdrData(mdrData),
        .bus(busData)
    );

    registerFile registerFile_i (
        .Clock(Clock), .rstN(rstN), .bus(busData), .regIn(regIn), .regData(regData)
    );

    memInterface memInterface_i (
        .Clock(Clock), .rstN(rstN), .bus(busData), .mDataIn(mDataIn),
        .read(read), .mdrIn(mdrIn), .marIn(marIn),
        .mdrData(mdrData), .marValue(marValue)
    );

    controlRegs controlRegs_i (
        .Clock(Clock), .rstN(rstN), .bus(busData),
        .pcIn(pcIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
        .pcData(pcData), .irValue(irValue), .hiData(hiData), .loData(loData)
    );

    aluUnit aluUnit_i (
        .Clock(Clock), .rstN(rstN), .bus(busData),
        .yIn(yIn), .zIn(zIn), .incPc(incPc), .opcode(opcode),
        .zData(zData)
    );

endmodule

/* src/datapath_cfg.svh */
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// Width of the shared bus and of every register.
`define DATA_WIDTH 32

// Number of general registers.
`define REG_COUNT 16

// Width of the ALU function select.
`define OPCODE_WIDTH 5

`endif

/* src/datapath_pkg.sv */
`include "datapath_cfg.svh"

package datapath_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [2*`DATA_WIDTH-1:0] dword_t;
    typedef logic [`REG_COUNT-1:0] regSel_t;
    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;

    // ALU function codes.
    localparam opcode_t OP_ADD  = 5'b00011;
    localparam opcode_t OP_SUB  = 5'b00100;
    localparam opcode_t OP_SHR  = 5'b00101;
    localparam opcode_t OP_SHRA = 5'b00110;
    localparam opcode_t OP_SHL  = 5'b00111;
    localparam opcode_t OP_ROR  = 5'b01000;
    localparam opcode_t OP_ROL  = 5'b01001;
    localparam opcode_t OP_AND  = 5'b01010;
    localparam opcode_t OP_OR   = 5'b01011;
    localparam opcode_t OP_MUL  = 5'b01111;
    localparam opcode_t OP_DIV  = 5'b10000;
    localparam opcode_t OP_NEG  = 5'b10001;
    localparam opcode_t OP_NOT  = 5'b10010;

    // Which unit currently drives the bus.
    typedef enum logic [2:0] {
        SRC_NONE, SRC_REG, SRC_PC, SRC_ZHIGH, SRC_ZLOW, SRC_HI, SRC_LO, SRC_MDR
    } busSrc_t;

endpackage

/* src/memInterface.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module memInterface (
    input  logic                Clock,
    input  logic                rstN,
    input  datapath_pkg::word_t bus,
    input  datapath_pkg::word_t mDataIn,
    input  logic                read,
    input  logic                mdrIn,
    input  logic                marIn,
    output datapath_pkg::word_t mdrData,
    output datapath_pkg::word_t marValue
);

    datapath_pkg::word_t mdrNext;

    // Memory data during a read cycle, otherwise the bus.
    assign mdrNext = read ? mDataIn : bus;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrData  <= '0;
            marValue <= '0;
        end else begin
            if (mdrIn) begin
                mdrData <= mdrNext;
            end
            if (marIn) begin
                marValue <= bus;
            end
        end
    end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module registerFile (
    input  logic                  Clock,
    input  logic                  rstN,
    input  datapath_pkg::word_t   bus,
    input  datapath_pkg::regSel_t regIn,
    output datapath_pkg::word_t   regData [`REG_COUNT]
);

    datapath_pkg::word_t regs [`REG_COUNT];

    // Each register has its own load strobe, so several can take the bus at once.
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regData[i] = regs[i];
        end
    end

endmodule
